// ==== source/rv_macros.svh ====
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

// major opcode field, inst[6:0]
`define RV_OP_LUI    7'b0110111
`define RV_OP_IMM    7'b0010011
`define RV_OP_REG    7'b0110011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

`endif

// ==== source/rv_pkg.sv ====
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [6:0] {
        op_lui     = `RV_OP_LUI,
        op_imm     = `RV_OP_IMM,
        op_reg     = `RV_OP_REG,
        op_load    = `RV_OP_LOAD,
        op_store   = `RV_OP_STORE,
        op_branch  = `RV_OP_BRANCH,
        op_jal     = `RV_OP_JAL,
        op_invalid = 7'b0000000
    } opcode_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_memory,
        st_commit
    } state_t;

    typedef struct packed {
        opcode_t   opcode;
        alu_op_t   alu_op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
        logic      reg_write;
    } dec_t;

endpackage

// ==== source/commit_if.sv ====
`timescale 1ns/100ps

interface commit_if;
    import rv_pkg::*;

    logic      valid;
    addr_t     pc;
    inst_t     inst;
    logic      wen;
    reg_addr_t wdest;
    word_t     wdata;

    modport source (
        output valid, pc, inst, wen, wdest, wdata
    );

    modport sink (
        input valid, pc, inst, wen, wdest, wdata
    );

endinterface

// ==== source/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t raddr1,
    input  rv_pkg::reg_addr_t raddr2,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2,
    input  logic              wen,
    input  rv_pkg::reg_addr_t waddr,
    input  rv_pkg::word_t     wdata
);
    import rv_pkg::*;

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

// ==== source/exec_unit.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module exec_unit (
    input  rv_pkg::inst_t inst,
    input  rv_pkg::addr_t pc,
    input  rv_pkg::word_t rs1_val,
    input  rv_pkg::word_t rs2_val,
    output rv_pkg::dec_t  dec,
    output rv_pkg::word_t result,
    output rv_pkg::addr_t mem_addr,
    output rv_pkg::addr_t next_pc
);
    import rv_pkg::*;

    logic       supported;
    inst_t      ie;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      alu_b;
    word_t      alu_out;
    logic       taken;

    // anything outside the subset runs as a nop
    always_comb begin
        funct3 = inst[14:12];
        funct7 = inst[31:25];
        case (inst[6:0])
            op_lui, op_jal: supported = 1'b1;
            op_imm: supported = (funct3 == 3'b000);
            op_load, op_store: supported = (funct3 == 3'b010);
            op_branch: supported = (funct3 == 3'b000) || (funct3 == 3'b001);
            // shifts and sltu are left out of the subset
            op_reg: supported = (funct7 == 7'h00 && funct3 != 3'b001 &&
                                 funct3 != 3'b011 && funct3 != 3'b101) ||
                                (funct7 == 7'h20 && funct3 == 3'b000);
            default: supported = 1'b0;
        endcase
    end

    assign ie = supported ? inst : `RV_NOP;

    always_comb begin
        dec.rs1       = ie[19:15];
        dec.rs2       = ie[24:20];
        dec.rd        = ie[11:7];
        dec.alu_op    = alu_add;
        dec.imm       = {{20{ie[31]}}, ie[31:20]};
        dec.reg_write = 1'b0;
        case (ie[6:0])
            op_lui: begin
                dec.opcode    = op_lui;
                dec.alu_op    = alu_pass_b;
                dec.imm       = {ie[31:12], 12'b0};
                dec.reg_write = 1'b1;
            end
            op_imm: begin
                dec.opcode    = op_imm;
                dec.reg_write = 1'b1;
            end
            op_reg: begin
                dec.opcode    = op_reg;
                dec.reg_write = 1'b1;
                case (ie[14:12])
                    3'b111:  dec.alu_op = alu_and;
                    3'b110:  dec.alu_op = alu_or;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b010:  dec.alu_op = alu_slt;
                    default: dec.alu_op = ie[30] ? alu_sub : alu_add;
                endcase
            end
            op_load: begin
                dec.opcode    = op_load;
                dec.reg_write = 1'b1;
            end
            op_store: begin
                dec.opcode = op_store;
                dec.imm    = {{20{ie[31]}}, ie[31:25], ie[11:7]};
            end
            op_branch: begin
                dec.opcode = op_branch;
                dec.imm    = {{19{ie[31]}}, ie[31], ie[7], ie[30:25], ie[11:8], 1'b0};
            end
            op_jal: begin
                dec.opcode    = op_jal;
                dec.imm       = {{11{ie[31]}}, ie[31], ie[19:12], ie[20], ie[30:21], 1'b0};
                dec.reg_write = 1'b1;
            end
            default: dec.opcode = op_invalid;
        endcase
        // rd of x0 never counts as a write
        if (dec.rd == 5'd0) begin
            dec.reg_write = 1'b0;
        end
    end

    assign alu_b = (dec.opcode == op_reg) ? rs2_val : dec.imm;

    always_comb begin
        case (dec.alu_op)
            alu_sub:    alu_out = rs1_val - alu_b;
            alu_and:    alu_out = rs1_val & alu_b;
            alu_or:     alu_out = rs1_val | alu_b;
            alu_xor:    alu_out = rs1_val ^ alu_b;
            alu_slt:    alu_out = {31'b0, $signed(rs1_val) < $signed(alu_b)};
            alu_pass_b: alu_out = alu_b;
            default:    alu_out = rs1_val + alu_b;
        endcase
    end

    // bne is funct3 001, beq is 000
    assign taken = (dec.opcode == op_jal) ||
                   (dec.opcode == op_branch && ((rs1_val == rs2_val) ^ ie[12]));

    assign result   = (dec.opcode == op_jal) ? pc + 32'd4 : alu_out;
    assign mem_addr = rs1_val + dec.imm;
    assign next_pc  = taken ? pc + dec.imm : pc + 32'd4;

endmodule

// ==== source/riscv.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module riscv (
    input  logic          clk,
    input  logic          rst,
    output logic          ireq_valid,
    output rv_pkg::addr_t ireq_addr,
    input  logic          iresp_ready,
    input  rv_pkg::inst_t iresp_data,
    output logic          dreq_valid,
    output logic          dreq_write,
    output rv_pkg::addr_t dreq_addr,
    output rv_pkg::word_t dreq_wdata,
    input  logic          dresp_ready,
    input  rv_pkg::word_t dresp_data,
    commit_if.source      trace
);
    import rv_pkg::*;

    state_t state;
    addr_t  pc;
    inst_t  inst;
    word_t  alu_res;
    addr_t  npc;
    word_t  load_data;

    dec_t   dec;
    word_t  rs1_val;
    word_t  rs2_val;
    word_t  result;
    addr_t  mem_addr;
    addr_t  next_pc;
    logic   is_mem;
    logic   rf_wen;
    word_t  wb_data;

    regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_val),
        .rdata2 (rs2_val),
        .wen    (rf_wen),
        .waddr  (dec.rd),
        .wdata  (wb_data)
    );

    exec_unit u_exec_unit (
        .inst     (inst),
        .pc       (pc),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .dec      (dec),
        .result   (result),
        .mem_addr (mem_addr),
        .next_pc  (next_pc)
    );

    assign is_mem = (dec.opcode == op_load) || (dec.opcode == op_store);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= st_fetch;
            pc         <= `RV_RESET_PC;
            ireq_valid <= 1'b0;
            dreq_valid <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    // request held until the memory answers
                    if (ireq_valid && iresp_ready) begin
                        ireq_valid <= 1'b0;
                        state      <= st_execute;
                    end else begin
                        ireq_valid <= 1'b1;
                    end
                end
                st_execute: begin
                    if (is_mem) begin
                        dreq_valid <= 1'b1;
                        state      <= st_memory;
                    end else begin
                        state <= st_commit;
                    end
                end
                st_memory: begin
                    if (dresp_ready) begin
                        dreq_valid <= 1'b0;
                        state      <= st_commit;
                    end
                end
                default: begin
                    pc    <= npc;
                    state <= st_fetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && ireq_valid && iresp_ready) begin
            inst <= iresp_data;
        end
        if (state == st_execute) begin
            alu_res    <= result;
            npc        <= next_pc;
            dreq_write <= (dec.opcode == op_store);
            dreq_addr  <= mem_addr;
            dreq_wdata <= rs2_val;
        end
        if (state == st_memory && dresp_ready) begin
            load_data <= dresp_data;
        end
    end

    assign ireq_addr = pc;

    assign wb_data = (dec.opcode == op_load) ? load_data : alu_res;
    assign rf_wen  = (state == st_commit) && dec.reg_write;

    assign trace.valid = (state == st_commit);
    assign trace.pc    = pc;
    assign trace.inst  = inst;
    assign trace.wen   = rf_wen;
    assign trace.wdest = dec.rd;
    assign trace.wdata = wb_data;

endmodule

// ==== source/core.sv ====
`timescale 1ns/100ps

module core (
    input  logic              clk,
    input  logic              reset,
    output logic              ireq_valid,
    output rv_pkg::addr_t     ireq_addr,
    input  logic              iresp_ready,
    input  rv_pkg::inst_t     iresp_data,
    output logic              dreq_valid,
    output logic              dreq_write,
    output rv_pkg::addr_t     dreq_addr,
    output rv_pkg::word_t     dreq_wdata,
    input  logic              dresp_ready,
    input  rv_pkg::word_t     dresp_data,
    output logic              commit_valid,
    output rv_pkg::addr_t     commit_pc,
    output rv_pkg::inst_t     commit_inst,
    output logic              commit_wen,
    output rv_pkg::reg_addr_t commit_wdest,
    output rv_pkg::word_t     commit_wdata
);

    logic core_rst;

    commit_if trace_bus ();

    // processor stays in reset one clock past the external release
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            core_rst <= 1'b1;
        end else begin
            core_rst <= 1'b0;
        end
    end

    riscv u_riscv (
        .clk         (clk),
        .rst         (core_rst),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .iresp_ready (iresp_ready),
        .iresp_data  (iresp_data),
        .dreq_valid  (dreq_valid),
        .dreq_write  (dreq_write),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dresp_ready (dresp_ready),
        .dresp_data  (dresp_data),
        .trace       (trace_bus.source)
    );

    assign commit_valid = trace_bus.valid;
    assign commit_pc    = trace_bus.pc;
    assign commit_inst  = trace_bus.inst;

    // write fields trail the commit record by one cycle for the checker
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            commit_wen   <= 1'b0;
            commit_wdest <= '0;
            commit_wdata <= '0;
        end else begin
            commit_wen   <= trace_bus.wen;
            commit_wdest <= trace_bus.wdest;
            commit_wdata <= trace_bus.wdata;
        end
    end

endmodule

// ==== testbench/tb_mem.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_mem (
    input  logic          clk,
    input  logic          ireq_valid,
    input  rv_pkg::addr_t ireq_addr,
    output logic          iresp_ready,
    output rv_pkg::inst_t iresp_data,
    input  logic          dreq_valid,
    input  logic          dreq_write,
    input  rv_pkg::addr_t dreq_addr,
    input  rv_pkg::word_t dreq_wdata,
    output logic          dresp_ready,
    output rv_pkg::word_t dresp_data
);
    import rv_pkg::*;

    word_t       words [0:255];
    logic [31:0] rng;
    logic        ibusy;
    logic        dbusy;
    logic [2:0]  iwait;
    logic [2:0]  dwait;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // 1 KiB window starting at the reset pc
    function automatic logic in_window(input addr_t addr);
        return (addr >> 10) == ((`RV_RESET_PC) >> 10);
    endfunction

    function automatic word_t read_word(input addr_t addr);
        return in_window(addr) ? words[addr[9:2]] : `RV_NOP;
    endfunction

    function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3,
                                     input reg_addr_t rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_REG};
    endfunction

    function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                     input logic [2:0] f3, input reg_addr_t rd,
                                     input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic inst_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic inst_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                     input reg_addr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd);
        return {imm, rd, `RV_OP_LUI};
    endfunction

    function automatic inst_t j_type(input logic [20:0] imm, input reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    initial begin
        iresp_ready = 1'b0;
        iresp_data  = '0;
        dresp_ready = 1'b0;
        dresp_data  = '0;
        ibusy       = 1'b0;
        dbusy       = 1'b0;
        iwait       = '0;
        dwait       = '0;
        rng         = 32'he990;
        for (int i = 0; i < 256; i++) begin
            words[i] = `RV_NOP;
        end
        words[0]  = u_type(20'h80000, 5'd1);
        words[1]  = i_type(12'd5, 5'd0, 3'b000, 5'd2, `RV_OP_IMM);
        words[2]  = i_type(-12'sd3, 5'd0, 3'b000, 5'd3, `RV_OP_IMM);
        words[3]  = r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4);
        words[4]  = r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5);
        words[5]  = r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd6);
        words[6]  = r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd7);
        words[7]  = r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8);
        words[8]  = r_type(7'h00, 5'd2, 5'd3, 3'b010, 5'd9);
        words[9]  = r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd10);
        // store then load back through x1 + 0x100
        words[10] = s_type(12'h100, 5'd5, 5'd1);
        words[11] = i_type(12'h100, 5'd1, 3'b010, 5'd11, `RV_OP_LOAD);
        words[12] = i_type(12'd7, 5'd2, 3'b000, 5'd0, `RV_OP_IMM);
        words[13] = i_type(12'd9, 5'd0, 3'b000, 5'd12, `RV_OP_IMM);
        words[14] = b_type(13'd8, 5'd5, 5'd2, 3'b000);
        words[15] = b_type(13'd8, 5'd5, 5'd2, 3'b001);
        words[16] = i_type(12'd1, 5'd0, 3'b000, 5'd13, `RV_OP_IMM);
        words[17] = b_type(13'd8, 5'd5, 5'd11, 3'b000);
        words[18] = i_type(12'd2, 5'd0, 3'b000, 5'd13, `RV_OP_IMM);
        words[19] = b_type(13'd8, 5'd4, 5'd4, 3'b001);
        words[20] = j_type(21'd8, 5'd14);
        words[21] = i_type(12'd3, 5'd0, 3'b000, 5'd13, `RV_OP_IMM);
        words[22] = r_type(7'h00, 5'd12, 5'd11, 3'b000, 5'd15);
        words[23] = j_type(21'd0, 5'd0);
    end

    // ready lasts one cycle, then the bus idles until the next request
    always @(posedge clk) begin
        if (iresp_ready) begin
            iresp_ready <= 1'b0;
        end else if (ireq_valid && !ibusy) begin
            rng = xorshift(rng);
            iwait <= rng[2:0];
            ibusy <= 1'b1;
        end else if (ireq_valid && iwait == 3'd0) begin
            iresp_ready <= 1'b1;
            iresp_data  <= read_word(ireq_addr);
            ibusy       <= 1'b0;
        end else if (ireq_valid) begin
            iwait <= iwait - 3'd1;
        end

        if (dresp_ready) begin
            dresp_ready <= 1'b0;
        end else if (dreq_valid && !dbusy) begin
            rng = xorshift(rng);
            dwait <= rng[2:0];
            dbusy <= 1'b1;
        end else if (dreq_valid && dwait == 3'd0) begin
            dresp_ready <= 1'b1;
            dresp_data  <= read_word(dreq_addr);
            dbusy       <= 1'b0;
            if (dreq_write && in_window(dreq_addr)) begin
                words[dreq_addr[9:2]] <= dreq_wdata;
            end
        end else if (dreq_valid) begin
            dwait <= dwait - 3'd1;
        end
    end

endmodule

// ==== testbench/tb_core.sv ====
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_core;
    import rv_pkg::*;

    localparam int RUN_COMMITS = 25;

    logic      clk;
    logic      reset;
    logic      reset_d;
    logic      fetched;
    logic      ireq_valid;
    addr_t     ireq_addr;
    logic      iresp_ready;
    inst_t     iresp_data;
    logic      dreq_valid;
    logic      dreq_write;
    addr_t     dreq_addr;
    word_t     dreq_wdata;
    logic      dresp_ready;
    word_t     dresp_data;
    logic      commit_valid;
    addr_t     commit_pc;
    inst_t     commit_inst;
    logic      commit_wen;
    reg_addr_t commit_wdest;
    word_t     commit_wdata;

    addr_t     exp_pc [0:31];
    logic      exp_wen [0:31];
    reg_addr_t exp_wdest [0:31];
    word_t     exp_wdata [0:31];
    int        n_exp;
    int        commits;
    int        errors;

    addr_t     want_pc;
    inst_t     want_inst;
    logic      want_wen;
    reg_addr_t want_wdest;
    word_t     want_wdata;
    logic      want_wen_d;
    reg_addr_t want_wdest_d;
    word_t     want_wdata_d;

    core dut (.*);

    tb_mem mem (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic value_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        errors++;
        $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, want, $time);
    endtask

    task automatic flag_error(input string what);
        errors++;
        $display("ERROR: %s at %0t", what, $time);
    endtask

    task automatic add_commit(input logic [31:0] off, input logic wen, input reg_addr_t rd,
                              input word_t val);
        exp_pc[n_exp]    = `RV_RESET_PC + off;
        exp_wen[n_exp]   = wen;
        exp_wdest[n_exp] = rd;
        exp_wdata[n_exp] = val;
        n_exp++;
    endtask

    task automatic finish_run();
        $display("%0d errors after %0d commits", errors, commits);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    // past the table the core spins on the jal at offset 0x5c
    always_comb begin
        if (commits < n_exp) begin
            want_pc    = exp_pc[commits];
            want_wen   = exp_wen[commits];
            want_wdest = exp_wdest[commits];
            want_wdata = exp_wdata[commits];
        end else begin
            want_pc    = `RV_RESET_PC + 32'h5c;
            want_wen   = 1'b0;
            want_wdest = '0;
            want_wdata = '0;
        end
        want_inst = mem.words[want_pc[9:2]];
    end

    always @(posedge clk) begin
        reset_d      <= reset;
        want_wen_d   <= want_wen;
        want_wdest_d <= want_wdest;
        want_wdata_d <= want_wdata;
        if (ireq_valid) begin
            fetched <= 1'b1;
        end
        if (!reset && commit_valid) begin
            commits <= commits + 1;
        end
    end

    quiet_in_reset: assert property (@(posedge clk) (reset || reset_d) |->
        !ireq_valid && !dreq_valid && !commit_valid && !commit_wen)
        else flag_error("bus or commit activity while the core is in reset");
    first_fetch_timing: assert property (@(posedge clk) (reset_d && !reset) |=>
        !ireq_valid ##1 ireq_valid)
        else flag_error("first instruction request not one clock after internal reset");
    first_fetch_addr: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !fetched |-> ireq_addr == `RV_RESET_PC)
        else value_mismatch("ireq_addr", $sampled(ireq_addr), `RV_RESET_PC);

    pc_matches: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_pc == want_pc)
        else value_mismatch("commit_pc", $sampled(commit_pc), $sampled(want_pc));
    inst_matches: assert property (@(posedge clk) disable iff (reset)
        commit_valid |-> commit_inst == want_inst)
        else value_mismatch("commit_inst", $sampled(commit_inst), $sampled(want_inst));

    // write fields trail commit_valid by exactly one cycle
    wen_follows: assert property (@(posedge clk) disable iff (reset)
        commit_valid |=> commit_wen == want_wen_d)
        else value_mismatch("commit_wen", $sampled(commit_wen), $sampled(want_wen_d));
    wdest_follows: assert property (@(posedge clk) disable iff (reset)
        commit_valid && want_wen |=> commit_wdest == want_wdest_d)
        else value_mismatch("commit_wdest", $sampled(commit_wdest), $sampled(want_wdest_d));
    wdata_follows: assert property (@(posedge clk) disable iff (reset)
        commit_valid && want_wen |=> commit_wdata == want_wdata_d)
        else value_mismatch("commit_wdata", $sampled(commit_wdata), $sampled(want_wdata_d));
    no_stray_wen: assert property (@(posedge clk) disable iff (reset)
        !commit_valid |=> !commit_wen)
        else flag_error("commit_wen high without a commit one cycle earlier");

    ibus_stable: assert property (@(posedge clk) disable iff (reset)
        ireq_valid && !iresp_ready |=> ireq_valid && $stable(ireq_addr))
        else flag_error("instruction request changed before ready");
    dbus_stable: assert property (@(posedge clk) disable iff (reset)
        dreq_valid && !dresp_ready |=>
        dreq_valid && $stable({dreq_write, dreq_addr, dreq_wdata}))
        else flag_error("data request changed before ready");

    // the only data accesses are the sw and lw at x1 + 0x100
    data_addr: assert property (@(posedge clk) disable iff (reset)
        dreq_valid |-> dreq_addr == 32'h8000_0100)
        else value_mismatch("dreq_addr", $sampled(dreq_addr), 32'h8000_0100);
    store_data: assert property (@(posedge clk) disable iff (reset)
        dreq_valid && dreq_write |-> dreq_wdata == 32'h8)
        else value_mismatch("dreq_wdata", $sampled(dreq_wdata), 32'h8);

    initial begin
        reset   = 1'b1;
        reset_d = 1'b1;
        fetched = 1'b0;
        commits = 0;
        errors  = 0;
        n_exp   = 0;
        add_commit(32'h00, 1'b1, 5'd1, 32'h8000_0000);
        add_commit(32'h04, 1'b1, 5'd2, 32'h5);
        add_commit(32'h08, 1'b1, 5'd3, 32'hffff_fffd);
        add_commit(32'h0c, 1'b1, 5'd4, 32'h2);
        add_commit(32'h10, 1'b1, 5'd5, 32'h8);
        add_commit(32'h14, 1'b1, 5'd6, 32'h5);
        add_commit(32'h18, 1'b1, 5'd7, 32'hffff_fffd);
        add_commit(32'h1c, 1'b1, 5'd8, 32'hffff_fff8);
        add_commit(32'h20, 1'b1, 5'd9, 32'h1);
        add_commit(32'h24, 1'b1, 5'd10, 32'h0);
        add_commit(32'h28, 1'b0, 5'd0, 32'h0);
        add_commit(32'h2c, 1'b1, 5'd11, 32'h8);
        add_commit(32'h30, 1'b0, 5'd0, 32'h0);
        add_commit(32'h34, 1'b1, 5'd12, 32'h9);
        add_commit(32'h38, 1'b0, 5'd0, 32'h0);
        add_commit(32'h3c, 1'b0, 5'd0, 32'h0);
        add_commit(32'h44, 1'b0, 5'd0, 32'h0);
        add_commit(32'h4c, 1'b0, 5'd0, 32'h0);
        add_commit(32'h50, 1'b1, 5'd14, 32'h8000_0054);
        add_commit(32'h58, 1'b1, 5'd15, 32'h11);
        add_commit(32'h5c, 1'b0, 5'd0, 32'h0);
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (commits >= RUN_COMMITS);
        repeat (2) @(posedge clk);
        finish_run();
    end

    // 40 instructions at up to 40 cycles each
    initial begin
        #(40 * 40 * 100);
        flag_error("watchdog expired before the program retired");
        finish_run();
    end

endmodule

// ==== tb.f ====
+incdir+source
source/rv_pkg.sv
source/commit_if.sv
source/regfile.sv
source/exec_unit.sv
source/riscv.sv
source/core.sv
testbench/tb_mem.sv
testbench/tb_core.sv
